/* hdl/lc3b_settings.svh */
// LC-3b core settings for word and register widths and reset values
`ifndef LC3B_SETTINGS_SVH
`define LC3B_SETTINGS_SVH

// Data and address width
`define LC3B_WORD_W 16

// Register index width and register count
`define LC3B_REG_W 3
`define LC3B_NREGS 8

// First fetch address
`define LC3B_PC_RESET 16'h0000

`endif

/* hdl/lc3b_isa_pkg.sv */
// LC-3b instruction encoding with opcode values and the two views of an IR word
`include "lc3b_settings.svh"

package lc3b_isa_pkg;

	localparam logic [3:0] OP_BR  = 4'b0000;
	localparam logic [3:0] OP_ADD = 4'b0001;
	localparam logic [3:0] OP_AND = 4'b0101;
	localparam logic [3:0] OP_LDR = 4'b0110;
	localparam logic [3:0] OP_STR = 4'b0111;
	localparam logic [3:0] OP_NOT = 4'b1001;

	// Register form of the low five bits
	typedef struct packed {
		logic [1:0] pad;
		logic [`LC3B_REG_W-1:0] src2;
	} lc3b_src2_field_t;

	typedef union packed {
		logic [4:0] imm5;
		lc3b_src2_field_t reg_form;
	} lc3b_operand_u;

	typedef struct packed {
		logic [3:0] opcode;
		logic [`LC3B_REG_W-1:0] dest;
		logic [`LC3B_REG_W-1:0] src1;
		logic imm_flag;
		lc3b_operand_u operand;
	} lc3b_rr_view_t;

	typedef struct packed {
		logic [`LC3B_REG_W-1:0] base;
		logic [5:0] offset6;
	} lc3b_based_t;

	typedef union packed {
		logic [8:0] offset9;
		lc3b_based_t based;
	} lc3b_offset_u;

	// nzp for BR, data register for LDR and STR
	typedef struct packed {
		logic [3:0] opcode;
		logic [`LC3B_REG_W-1:0] nzp_dr;
		lc3b_offset_u offset;
	} lc3b_off_view_t;

	typedef union packed {
		logic [`LC3B_WORD_W-1:0] raw;
		lc3b_rr_view_t rr;
		lc3b_off_view_t off;
	} lc3b_instr_u;

endpackage

/* hdl/lc3b_pipe_pkg.sv */
// LC-3b pipeline control encodings for operand forwarding and ALU operations
package lc3b_pipe_pkg;

	// Where execute takes a source operand from
	localparam logic [1:0] FWD_RF    = 2'd0;
	localparam logic [1:0] FWD_EXMEM = 2'd1;
	localparam logic [1:0] FWD_MEMWB = 2'd2;

	// ALU operations
	localparam logic [1:0] ALU_ADD  = 2'd0;
	localparam logic [1:0] ALU_AND  = 2'd1;
	localparam logic [1:0] ALU_NOT  = 2'd2;
	// Address adder output straight through
	localparam logic [1:0] ALU_PASS = 2'd3;

endpackage

/* hdl/lc3b_fetch.sv */
// LC-3b fetch stage with program counter, next-PC choice and IF/ID register
`timescale 1ns/1ps
`include "lc3b_settings.svh"

module lc3b_fetch
	import lc3b_isa_pkg::*;
(
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_hold,
	input  logic i_load_use_stall,
	input  logic i_br_taken,
	input  logic [`LC3B_WORD_W-1:0] i_br_target,
	input  logic [`LC3B_WORD_W-1:0] i_imem_rdata,
	output logic [`LC3B_WORD_W-1:0] o_imem_addr,
	output logic o_imem_read,
	output logic o_ifid_valid,
	output lc3b_instr_u o_ifid_ir,
	output logic [`LC3B_WORD_W-1:0] o_ifid_pc
);

	logic [`LC3B_WORD_W-1:0] pc;
	logic [`LC3B_WORD_W-1:0] pc_plus2;
	logic advance;

	assign pc_plus2 = pc + 'd2;
	assign o_imem_addr = pc;
	// Instruction port always requests
	assign o_imem_read = 1'b1;
	assign advance = !i_hold && !i_load_use_stall;

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			pc <= `LC3B_PC_RESET;
			o_ifid_valid <= 1'b0;
		end
		else if (!i_hold && i_br_taken)
		begin
			pc <= i_br_target;
			o_ifid_valid <= 1'b0;
		end
		else if (advance)
		begin
			pc <= pc_plus2;
			o_ifid_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			o_ifid_ir.raw <= i_imem_rdata;
			o_ifid_pc <= pc_plus2;
		end
	end

	// Request stays up and its address steady through a hold
	a_imem_req: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_imem_read and (i_hold |=> $stable(o_imem_addr)));

endmodule

/* hdl/lc3b_decode.sv */
// LC-3b decode stage with control decode, register file, load-use check and ID/EX register
`timescale 1ns/1ps
`include "lc3b_settings.svh"

module lc3b_decode
	import lc3b_isa_pkg::*;
(
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_hold,
	input  logic i_flush,
	input  logic i_ifid_valid,
	input  lc3b_instr_u i_ifid_ir,
	input  logic [`LC3B_WORD_W-1:0] i_ifid_pc,
	input  logic i_wb_load_reg,
	input  logic [`LC3B_REG_W-1:0] i_wb_dest,
	input  logic [`LC3B_WORD_W-1:0] i_wb_data,
	output logic o_load_use_stall,
	output logic o_idex_valid,
	output lc3b_instr_u o_idex_ir,
	output logic [`LC3B_WORD_W-1:0] o_idex_pc,
	output logic [`LC3B_WORD_W-1:0] o_idex_sr1,
	output logic [`LC3B_WORD_W-1:0] o_idex_sr2,
	output logic [`LC3B_REG_W-1:0] o_idex_src1,
	output logic [`LC3B_REG_W-1:0] o_idex_src2,
	output logic [`LC3B_REG_W-1:0] o_idex_dest,
	output logic o_idex_load_reg,
	output logic o_idex_mem_read,
	output logic o_idex_mem_write,
	output logic o_idex_br
);

	logic [3:0] opcode;
	logic is_arith;
	logic is_not;
	logic is_ldr;
	logic is_str;
	logic uses_src1;
	logic uses_src2;
	logic [`LC3B_REG_W-1:0] src1;
	logic [`LC3B_REG_W-1:0] src2;
	logic [`LC3B_WORD_W-1:0] sr1_val;
	logic [`LC3B_WORD_W-1:0] sr2_val;
	logic [`LC3B_WORD_W-1:0] regs [`LC3B_NREGS];

	assign opcode = i_ifid_ir.rr.opcode;
	assign is_arith = (opcode == OP_ADD) || (opcode == OP_AND);
	assign is_not = (opcode == OP_NOT);
	assign is_ldr = (opcode == OP_LDR);
	assign is_str = (opcode == OP_STR);
	assign uses_src1 = is_arith || is_not || is_ldr || is_str;
	assign uses_src2 = (is_arith && !i_ifid_ir.rr.imm_flag) || is_str;
	assign src1 = i_ifid_ir.rr.src1;
	// STR reads its data register through the second port
	assign src2 = is_str ? i_ifid_ir.off.nzp_dr : i_ifid_ir.rr.operand.reg_form.src2;

	// Write-through of the value being written back
	assign sr1_val = (i_wb_load_reg && i_wb_dest == src1) ? i_wb_data : regs[src1];
	assign sr2_val = (i_wb_load_reg && i_wb_dest == src2) ? i_wb_data : regs[src2];

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			for (int i = 0; i < `LC3B_NREGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (i_wb_load_reg)
		begin
			regs[i_wb_dest] <= i_wb_data;
		end
	end

	// Load in EX whose data the next instruction needs
	assign o_load_use_stall = i_ifid_valid && o_idex_valid && o_idex_mem_read &&
		((uses_src1 && o_idex_dest == src1) || (uses_src2 && o_idex_dest == src2));

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_idex_valid <= 1'b0;
			o_idex_load_reg <= 1'b0;
			o_idex_mem_read <= 1'b0;
			o_idex_mem_write <= 1'b0;
			o_idex_br <= 1'b0;
		end
		else if (!i_hold)
		begin
			o_idex_valid <= i_ifid_valid && !i_flush && !o_load_use_stall;
			o_idex_load_reg <= is_arith || is_not || is_ldr;
			o_idex_mem_read <= is_ldr;
			o_idex_mem_write <= is_str;
			o_idex_br <= (opcode == OP_BR);
		end
	end

	always_ff @(posedge clk)
	begin
		if (!i_hold)
		begin
			o_idex_ir <= i_ifid_ir;
			o_idex_pc <= i_ifid_pc;
			o_idex_sr1 <= sr1_val;
			o_idex_sr2 <= sr2_val;
			o_idex_src1 <= src1;
			o_idex_src2 <= src2;
			o_idex_dest <= i_ifid_ir.rr.dest;
		end
	end

	// Writeback from the memory stage never targets an unknown register
	a_wb_dest_known: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_wb_load_reg |-> !$isunknown(i_wb_dest));

endmodule

/* hdl/lc3b_execute.sv */
// LC-3b execute stage with operand forwarding, ALU, address adder and EX/MEM register
`timescale 1ns/1ps
`include "lc3b_settings.svh"

module lc3b_execute
	import lc3b_isa_pkg::*;
	import lc3b_pipe_pkg::*;
(
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_hold,
	input  logic i_flush,
	input  logic i_idex_valid,
	input  lc3b_instr_u i_idex_ir,
	input  logic [`LC3B_WORD_W-1:0] i_idex_pc,
	input  logic [`LC3B_WORD_W-1:0] i_idex_sr1,
	input  logic [`LC3B_WORD_W-1:0] i_idex_sr2,
	input  logic [`LC3B_REG_W-1:0] i_idex_src1,
	input  logic [`LC3B_REG_W-1:0] i_idex_src2,
	input  logic [`LC3B_REG_W-1:0] i_idex_dest,
	input  logic i_idex_load_reg,
	input  logic i_idex_mem_read,
	input  logic i_idex_mem_write,
	input  logic i_idex_br,
	input  logic i_wb_load_reg,
	input  logic [`LC3B_REG_W-1:0] i_wb_dest,
	input  logic [`LC3B_WORD_W-1:0] i_wb_data,
	output logic o_exmem_valid,
	output lc3b_instr_u o_exmem_ir,
	output logic [`LC3B_WORD_W-1:0] o_exmem_result,
	output logic [`LC3B_WORD_W-1:0] o_exmem_store_data,
	output logic [`LC3B_REG_W-1:0] o_exmem_dest,
	output logic o_exmem_load_reg,
	output logic o_exmem_mem_read,
	output logic o_exmem_mem_write,
	output logic o_exmem_br
);

	logic exmem_fwd_ok;
	logic [1:0] fwd1_sel;
	logic [1:0] fwd2_sel;
	logic [1:0] alu_op;
	logic [`LC3B_WORD_W-1:0] opnd1;
	logic [`LC3B_WORD_W-1:0] opnd2;
	logic [`LC3B_WORD_W-1:0] imm5_sx;
	logic [`LC3B_WORD_W-1:0] off6_x2;
	logic [`LC3B_WORD_W-1:0] off9_x2;
	logic [`LC3B_WORD_W-1:0] alu_b;
	logic [`LC3B_WORD_W-1:0] address;
	logic [`LC3B_WORD_W-1:0] result;

	// A load holds its address in EX/MEM, not its data
	assign exmem_fwd_ok = o_exmem_valid && o_exmem_load_reg && !o_exmem_mem_read;

	function automatic logic [1:0] fwd_select(input logic [`LC3B_REG_W-1:0] src);
		if (exmem_fwd_ok && o_exmem_dest == src)
			return FWD_EXMEM;
		else if (i_wb_load_reg && i_wb_dest == src)
			return FWD_MEMWB;
		else
			return FWD_RF;
	endfunction

	function automatic logic [`LC3B_WORD_W-1:0] fwd_value(input logic [1:0] sel,
		input logic [`LC3B_WORD_W-1:0] rf_val);
		case (sel)
			FWD_EXMEM: return o_exmem_result;
			FWD_MEMWB: return i_wb_data;
			default: return rf_val;
		endcase
	endfunction

	always_comb
	begin
		fwd1_sel = fwd_select(i_idex_src1);
		fwd2_sel = fwd_select(i_idex_src2);
		opnd1 = fwd_value(fwd1_sel, i_idex_sr1);
		opnd2 = fwd_value(fwd2_sel, i_idex_sr2);
	end

	assign imm5_sx = {{(`LC3B_WORD_W-5){i_idex_ir.rr.operand.imm5[4]}},
		i_idex_ir.rr.operand.imm5};
	assign off6_x2 = {{(`LC3B_WORD_W-7){i_idex_ir.off.offset.based.offset6[5]}},
		i_idex_ir.off.offset.based.offset6, 1'b0};
	assign off9_x2 = {{(`LC3B_WORD_W-10){i_idex_ir.off.offset.offset9[8]}},
		i_idex_ir.off.offset.offset9, 1'b0};
	assign alu_b = i_idex_ir.rr.imm_flag ? imm5_sx : opnd2;
	// BR counts from PC+2, LDR and STR from the base register
	assign address = i_idex_br ? (i_idex_pc + off9_x2) : (opnd1 + off6_x2);

	always_comb
	begin
		case (i_idex_ir.rr.opcode)
			OP_ADD: alu_op = ALU_ADD;
			OP_AND: alu_op = ALU_AND;
			OP_NOT: alu_op = ALU_NOT;
			default: alu_op = ALU_PASS;
		endcase
		case (alu_op)
			ALU_ADD: result = opnd1 + alu_b;
			ALU_AND: result = opnd1 & alu_b;
			ALU_NOT: result = ~opnd1;
			default: result = address;
		endcase
	end

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_exmem_valid <= 1'b0;
			o_exmem_load_reg <= 1'b0;
			o_exmem_mem_read <= 1'b0;
			o_exmem_mem_write <= 1'b0;
			o_exmem_br <= 1'b0;
		end
		else if (!i_hold)
		begin
			o_exmem_valid <= i_idex_valid && !i_flush;
			o_exmem_load_reg <= i_idex_load_reg;
			o_exmem_mem_read <= i_idex_mem_read;
			o_exmem_mem_write <= i_idex_mem_write;
			o_exmem_br <= i_idex_br;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!i_hold)
		begin
			o_exmem_ir <= i_idex_ir;
			o_exmem_result <= result;
			o_exmem_store_data <= opnd2;
			o_exmem_dest <= i_idex_dest;
		end
	end

	// Load data is never needed by the instruction right behind it
	a_no_load_fwd: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_idex_valid && !i_idex_br && o_exmem_valid && o_exmem_mem_read
		|-> o_exmem_dest != i_idex_src1);

endmodule

/* hdl/lc3b_memory.sv */
// LC-3b memory stage with data port, condition codes, branch resolution, hold and writeback
`timescale 1ns/1ps
`include "lc3b_settings.svh"

module lc3b_memory
	import lc3b_isa_pkg::*;
(
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_imem_resp,
	input  logic i_exmem_valid,
	input  lc3b_instr_u i_exmem_ir,
	input  logic [`LC3B_WORD_W-1:0] i_exmem_result,
	input  logic [`LC3B_WORD_W-1:0] i_exmem_store_data,
	input  logic [`LC3B_REG_W-1:0] i_exmem_dest,
	input  logic i_exmem_load_reg,
	input  logic i_exmem_mem_read,
	input  logic i_exmem_mem_write,
	input  logic i_exmem_br,
	input  logic i_dmem_resp,
	input  logic [`LC3B_WORD_W-1:0] i_dmem_rdata,
	output logic [`LC3B_WORD_W-1:0] o_dmem_addr,
	output logic [`LC3B_WORD_W-1:0] o_dmem_wdata,
	output logic o_dmem_read,
	output logic o_dmem_write,
	output logic o_hold,
	output logic o_br_taken,
	output logic [`LC3B_WORD_W-1:0] o_br_target,
	output logic o_wb_load_reg,
	output logic [`LC3B_REG_W-1:0] o_wb_dest,
	output logic [`LC3B_WORD_W-1:0] o_wb_data
);

	logic [`LC3B_WORD_W-1:0] mem_value;
	logic [2:0] cc;
	logic [2:0] cc_next;
	logic wb_valid;
	logic wb_load_reg;
	logic wb_is_load;
	logic [`LC3B_WORD_W-1:0] wb_rdata;
	logic [`LC3B_WORD_W-1:0] wb_result;

	assign o_dmem_addr = i_exmem_result;
	assign o_dmem_wdata = i_exmem_store_data;
	assign o_dmem_read = i_exmem_valid && i_exmem_mem_read;
	assign o_dmem_write = i_exmem_valid && i_exmem_mem_write;

	// Whole pipeline waits on either memory
	assign o_hold = !i_imem_resp || ((o_dmem_read || o_dmem_write) && !i_dmem_resp);

	assign mem_value = i_exmem_mem_read ? i_dmem_rdata : i_exmem_result;
	assign cc_next = {mem_value[`LC3B_WORD_W-1], mem_value == '0,
		!mem_value[`LC3B_WORD_W-1] && mem_value != '0};

	assign o_br_taken = i_exmem_valid && i_exmem_br && |(i_exmem_ir.off.nzp_dr & cc);
	assign o_br_target = i_exmem_result;

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			cc <= 3'b000;
			wb_valid <= 1'b0;
			wb_load_reg <= 1'b0;
		end
		else if (!o_hold)
		begin
			// Flags follow the value leaving MEM
			if (i_exmem_valid && i_exmem_load_reg)
				cc <= cc_next;
			wb_valid <= i_exmem_valid;
			wb_load_reg <= i_exmem_load_reg;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!o_hold)
		begin
			o_wb_dest <= i_exmem_dest;
			wb_is_load <= i_exmem_mem_read;
			wb_rdata <= i_dmem_rdata;
			wb_result <= i_exmem_result;
		end
	end

	assign o_wb_load_reg = wb_valid && wb_load_reg;
	assign o_wb_data = wb_is_load ? wb_rdata : wb_result;

	a_dmem_rw_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(o_dmem_read && o_dmem_write));

	// Data request waits unchanged for its response
	a_dmem_req_held: assert property (@(posedge clk) disable iff (!i_rst_n)
		(o_dmem_read || o_dmem_write) && !i_dmem_resp |=>
		$stable(o_dmem_addr) && $stable(o_dmem_write) && $stable(o_dmem_read));

endmodule

/* hdl/lc3b_cpu_datapath.sv */
// LC-3b pipelined datapath joining fetch, decode, execute and memory stages
`timescale 1ns/1ps
`include "lc3b_settings.svh"

module lc3b_cpu_datapath
	import lc3b_isa_pkg::*;
(
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_imem_resp,
	input  logic [`LC3B_WORD_W-1:0] i_imem_rdata,
	output logic [`LC3B_WORD_W-1:0] o_imem_addr,
	output logic o_imem_read,
	input  logic i_dmem_resp,
	input  logic [`LC3B_WORD_W-1:0] i_dmem_rdata,
	output logic [`LC3B_WORD_W-1:0] o_dmem_addr,
	output logic [`LC3B_WORD_W-1:0] o_dmem_wdata,
	output logic o_dmem_read,
	output logic o_dmem_write
);

	logic hold;
	logic load_use_stall;
	logic br_taken;
	logic [`LC3B_WORD_W-1:0] br_target;
	logic wb_load_reg;
	logic [`LC3B_REG_W-1:0] wb_dest;
	logic [`LC3B_WORD_W-1:0] wb_data;
	logic ifid_valid;
	lc3b_instr_u ifid_ir;
	logic [`LC3B_WORD_W-1:0] ifid_pc;
	logic idex_valid;
	lc3b_instr_u idex_ir;
	logic [`LC3B_WORD_W-1:0] idex_pc;
	logic [`LC3B_WORD_W-1:0] idex_sr1;
	logic [`LC3B_WORD_W-1:0] idex_sr2;
	logic [`LC3B_REG_W-1:0] idex_src1;
	logic [`LC3B_REG_W-1:0] idex_src2;
	logic [`LC3B_REG_W-1:0] idex_dest;
	logic idex_load_reg;
	logic idex_mem_read;
	logic idex_mem_write;
	logic idex_br;
	logic exmem_valid;
	lc3b_instr_u exmem_ir;
	logic [`LC3B_WORD_W-1:0] exmem_result;
	logic [`LC3B_WORD_W-1:0] exmem_store_data;
	logic [`LC3B_REG_W-1:0] exmem_dest;
	logic exmem_load_reg;
	logic exmem_mem_read;
	logic exmem_mem_write;
	logic exmem_br;

	lc3b_fetch u_fetch
	(
		.clk,
		.i_rst_n,
		.i_hold(hold),
		.i_load_use_stall(load_use_stall),
		.i_br_taken(br_taken),
		.i_br_target(br_target),
		.i_imem_rdata,
		.o_imem_addr,
		.o_imem_read,
		.o_ifid_valid(ifid_valid),
		.o_ifid_ir(ifid_ir),
		.o_ifid_pc(ifid_pc)
	);

	lc3b_decode u_decode
	(
		.clk,
		.i_rst_n,
		.i_hold(hold),
		.i_flush(br_taken),
		.i_ifid_valid(ifid_valid),
		.i_ifid_ir(ifid_ir),
		.i_ifid_pc(ifid_pc),
		.i_wb_load_reg(wb_load_reg),
		.i_wb_dest(wb_dest),
		.i_wb_data(wb_data),
		.o_load_use_stall(load_use_stall),
		.o_idex_valid(idex_valid),
		.o_idex_ir(idex_ir),
		.o_idex_pc(idex_pc),
		.o_idex_sr1(idex_sr1),
		.o_idex_sr2(idex_sr2),
		.o_idex_src1(idex_src1),
		.o_idex_src2(idex_src2),
		.o_idex_dest(idex_dest),
		.o_idex_load_reg(idex_load_reg),
		.o_idex_mem_read(idex_mem_read),
		.o_idex_mem_write(idex_mem_write),
		.o_idex_br(idex_br)
	);

	lc3b_execute u_execute
	(
		.clk,
		.i_rst_n,
		.i_hold(hold),
		.i_flush(br_taken),
		.i_idex_valid(idex_valid),
		.i_idex_ir(idex_ir),
		.i_idex_pc(idex_pc),
		.i_idex_sr1(idex_sr1),
		.i_idex_sr2(idex_sr2),
		.i_idex_src1(idex_src1),
		.i_idex_src2(idex_src2),
		.i_idex_dest(idex_dest),
		.i_idex_load_reg(idex_load_reg),
		.i_idex_mem_read(idex_mem_read),
		.i_idex_mem_write(idex_mem_write),
		.i_idex_br(idex_br),
		.i_wb_load_reg(wb_load_reg),
		.i_wb_dest(wb_dest),
		.i_wb_data(wb_data),
		.o_exmem_valid(exmem_valid),
		.o_exmem_ir(exmem_ir),
		.o_exmem_result(exmem_result),
		.o_exmem_store_data(exmem_store_data),
		.o_exmem_dest(exmem_dest),
		.o_exmem_load_reg(exmem_load_reg),
		.o_exmem_mem_read(exmem_mem_read),
		.o_exmem_mem_write(exmem_mem_write),
		.o_exmem_br(exmem_br)
	);

	lc3b_memory u_memory
	(
		.clk,
		.i_rst_n,
		.i_imem_resp,
		.i_exmem_valid(exmem_valid),
		.i_exmem_ir(exmem_ir),
		.i_exmem_result(exmem_result),
		.i_exmem_store_data(exmem_store_data),
		.i_exmem_dest(exmem_dest),
		.i_exmem_load_reg(exmem_load_reg),
		.i_exmem_mem_read(exmem_mem_read),
		.i_exmem_mem_write(exmem_mem_write),
		.i_exmem_br(exmem_br),
		.i_dmem_resp,
		.i_dmem_rdata,
		.o_dmem_addr,
		.o_dmem_wdata,
		.o_dmem_read,
		.o_dmem_write,
		.o_hold(hold),
		.o_br_taken(br_taken),
		.o_br_target(br_target),
		.o_wb_load_reg(wb_load_reg),
		.o_wb_dest(wb_dest),
		.o_wb_data(wb_data)
	);

endmodule

/* verif/lc3b_tb.sv */
// LC-3b pipeline testbench with bus memories, ISA reference model and store checking
`timescale 1ns/1ps
`include "lc3b_settings.svh"

module lc3b_tb
	import lc3b_isa_pkg::*;
();

	logic clk;
	logic i_rst_n;
	logic i_imem_resp;
	logic [`LC3B_WORD_W-1:0] i_imem_rdata;
	logic [`LC3B_WORD_W-1:0] o_imem_addr;
	logic o_imem_read;
	logic i_dmem_resp;
	logic [`LC3B_WORD_W-1:0] i_dmem_rdata;
	logic [`LC3B_WORD_W-1:0] o_dmem_addr;
	logic [`LC3B_WORD_W-1:0] o_dmem_wdata;
	logic o_dmem_read;
	logic o_dmem_write;

	logic [`LC3B_WORD_W-1:0] imem [0:255];
	logic [`LC3B_WORD_W-1:0] dmem [0:255];
	logic [`LC3B_WORD_W-1:0] exp_addr [$];
	logic [`LC3B_WORD_W-1:0] exp_data [$];
	logic [`LC3B_WORD_W-1:0] halt_addr;
	logic [`LC3B_WORD_W-1:0] prev_fetch;
	logic [`LC3B_WORD_W-1:0] imem_addr_seen;
	int seed;
	int errors;
	int checks;
	int runs;
	int store_idx;
	int load_pc;
	int prog_len;
	int imem_wait;
	int dmem_wait;
	int run_cycles = 0;
	int cycle_limit = 0;
	logic running = 1'b0;
	logic timed_out = 1'b0;
	logic done;
	logic rand_delays;
	logic dmem_busy;
	logic dmem_retired;

	lc3b_cpu_datapath UUT
	(
		.clk,
		.i_rst_n,
		.i_imem_resp,
		.i_imem_rdata,
		.o_imem_addr,
		.o_imem_read,
		.i_dmem_resp,
		.i_dmem_rdata,
		.o_dmem_addr,
		.o_dmem_wdata,
		.o_dmem_read,
		.o_dmem_write
	);

	always #5 clk = ~clk;

	task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Initial data memory contents
	function automatic logic [15:0] fill_word(input int idx);
		return 16'(idx * 16'h0451 + 16'h2a07);
	endfunction

	function automatic int draw_delay();
		if (rand_delays)
			return $unsigned($random(seed)) % 4;
		return 0;
	endfunction

	function automatic logic [15:0] reg_form(input logic [3:0] op, input int dr, input int sr1,
		input int sr2);
		return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
	endfunction

	function automatic logic [15:0] imm_form(input logic [3:0] op, input int dr, input int sr1,
		input int imm);
		return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
	endfunction

	function automatic logic [15:0] not_instr(input int dr, input int sr);
		return {OP_NOT, 3'(dr), 3'(sr), 6'h3f};
	endfunction

	function automatic logic [15:0] mem_instr(input logic [3:0] op, input int r, input int base,
		input int off);
		return {op, 3'(r), 3'(base), 6'(off)};
	endfunction

	function automatic logic [15:0] br_instr(input int nzp, input int off);
		return {OP_BR, 3'(nzp), 9'(off)};
	endfunction

	function automatic logic [2:0] flags_of(input logic [15:0] v);
		return {v[15], v == 16'h0, !v[15] && v != 16'h0};
	endfunction

	task automatic emit(input logic [15:0] w);
		imem[load_pc] = w;
		load_pc++;
	endtask

	task automatic load_program(input int id);
		for (int i = 0; i < 256; i++)
		begin
			imem[i] = 16'h0000;
		end
		load_pc = 0;
		case (id)
			1:
			begin
				emit(imm_form(OP_ADD, 1, 0, 7));
				emit(imm_form(OP_ADD, 2, 1, 9));
				emit(reg_form(OP_ADD, 3, 1, 2));
				emit(reg_form(OP_AND, 4, 3, 2));
				emit(not_instr(5, 4));
				emit(reg_form(OP_ADD, 6, 5, 3));
				emit(reg_form(OP_AND, 7, 6, 1));
				emit(mem_instr(OP_STR, 7, 0, 0));
				emit(mem_instr(OP_STR, 6, 0, 1));
				emit(not_instr(1, 6));
				emit(reg_form(OP_ADD, 2, 1, 1));
				emit(mem_instr(OP_STR, 2, 0, 2));
				emit(mem_instr(OP_STR, 5, 0, 3));
				emit(mem_instr(OP_STR, 3, 0, 5));
			end
			2:
			begin
				emit(imm_form(OP_ADD, 1, 0, -16));
				emit(imm_form(OP_ADD, 1, 1, 15));
				emit(imm_form(OP_AND, 2, 1, -6));
				emit(imm_form(OP_ADD, 3, 2, -1));
				emit(not_instr(4, 3));
				emit(imm_form(OP_AND, 5, 4, 13));
				emit(imm_form(OP_ADD, 6, 5, -8));
				emit(imm_form(OP_ADD, 7, 0, 15));
				emit(imm_form(OP_ADD, 7, 7, 15));
				emit(mem_instr(OP_STR, 1, 0, 8));
				emit(mem_instr(OP_STR, 3, 0, 10));
				emit(mem_instr(OP_STR, 4, 0, 11));
				emit(mem_instr(OP_STR, 6, 7, -3));
				emit(imm_form(OP_ADD, 7, 6, -16));
				emit(mem_instr(OP_STR, 7, 0, 13));
			end
			3:
			begin
				emit(mem_instr(OP_LDR, 1, 0, 4));
				emit(imm_form(OP_ADD, 2, 1, 1));
				emit(mem_instr(OP_STR, 2, 0, 20));
				emit(mem_instr(OP_LDR, 3, 0, 5));
				emit(reg_form(OP_ADD, 4, 3, 1));
				emit(mem_instr(OP_STR, 4, 0, 21));
				emit(mem_instr(OP_LDR, 5, 0, 6));
				emit(mem_instr(OP_STR, 5, 0, 22));
				emit(mem_instr(OP_LDR, 6, 0, 7));
				emit(imm_form(OP_ADD, 7, 0, 3));
				emit(reg_form(OP_AND, 6, 6, 4));
				emit(mem_instr(OP_STR, 6, 0, 23));
				emit(reg_form(OP_ADD, 7, 7, 7));
				emit(mem_instr(OP_LDR, 1, 7, 10));
				emit(not_instr(2, 1));
				emit(mem_instr(OP_STR, 2, 0, 24));
			end
			default:
			begin
				emit(imm_form(OP_ADD, 6, 0, 15));
				emit(reg_form(OP_ADD, 6, 6, 6));
				emit(imm_form(OP_ADD, 1, 0, -2));
				emit(br_instr(3'b100, 1));
				emit(mem_instr(OP_STR, 1, 6, 0));
				emit(br_instr(3'b010, 1));
				emit(mem_instr(OP_STR, 1, 6, 1));
				emit(br_instr(3'b001, 1));
				emit(mem_instr(OP_STR, 1, 6, 2));
				emit(imm_form(OP_AND, 2, 0, 0));
				emit(br_instr(3'b010, 3));
				emit(mem_instr(OP_STR, 1, 6, 3));
				emit(mem_instr(OP_STR, 1, 6, 4));
				emit(mem_instr(OP_STR, 1, 6, 5));
				emit(br_instr(3'b100, 1));
				emit(mem_instr(OP_STR, 2, 6, 6));
				emit(br_instr(3'b001, 1));
				emit(mem_instr(OP_STR, 2, 6, 7));
				emit(imm_form(OP_ADD, 3, 0, 5));
				emit(br_instr(3'b001, 3));
				emit(mem_instr(OP_STR, 3, 6, 8));
				emit(mem_instr(OP_STR, 3, 6, 9));
				emit(mem_instr(OP_STR, 3, 6, 10));
				emit(br_instr(3'b100, 1));
				emit(mem_instr(OP_STR, 3, 6, 11));
				emit(br_instr(3'b010, 1));
				emit(mem_instr(OP_STR, 3, 6, 12));
				// Three passes through a backward branch
				emit(imm_form(OP_ADD, 4, 0, 3));
				emit(imm_form(OP_ADD, 5, 6, 14));
				emit(mem_instr(OP_STR, 4, 5, 0));
				emit(imm_form(OP_ADD, 5, 5, 2));
				emit(imm_form(OP_ADD, 4, 4, -1));
				emit(br_instr(3'b001, -4));
				emit(mem_instr(OP_STR, 5, 6, 15));
			end
		endcase
		halt_addr = 16'(2 * load_pc);
		emit(br_instr(3'b111, -1));
		prog_len = load_pc;
	endtask

	// ISA-level run of the loaded program, collecting the stores in order
	function automatic void run_reference();
		logic [15:0] r [0:7];
		logic [15:0] m [0:255];
		logic [15:0] pc;
		logic [15:0] ir;
		logic [15:0] b;
		logic [15:0] v;
		logic [15:0] addr;
		logic [2:0] cc;
		logic stop;
		int steps;
		exp_addr.delete();
		exp_data.delete();
		for (int i = 0; i < 8; i++)
		begin
			r[i] = 16'h0000;
		end
		for (int i = 0; i < 256; i++)
		begin
			m[i] = fill_word(i);
		end
		pc = `LC3B_PC_RESET;
		cc = 3'b000;
		stop = 1'b0;
		steps = 0;
		while (!stop && steps < 2000)
		begin
			ir = imem[pc[8:1]];
			pc = pc + 16'd2;
			steps++;
			addr = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
			b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
			case (ir[15:12])
				OP_ADD, OP_AND, OP_NOT:
				begin
					if (ir[15:12] == OP_ADD)
						v = r[ir[8:6]] + b;
					else if (ir[15:12] == OP_AND)
						v = r[ir[8:6]] & b;
					else
						v = ~r[ir[8:6]];
					r[ir[11:9]] = v;
					cc = flags_of(v);
				end
				OP_LDR:
				begin
					r[ir[11:9]] = m[addr[8:1]];
					cc = flags_of(m[addr[8:1]]);
				end
				OP_STR:
				begin
					m[addr[8:1]] = r[ir[11:9]];
					exp_addr.push_back(addr);
					exp_data.push_back(r[ir[11:9]]);
				end
				OP_BR:
				begin
					if (|(ir[11:9] & cc))
					begin
						addr = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
						stop = (addr == pc - 16'd2);
						pc = addr;
					end
				end
				default:
				begin
				end
			endcase
		end
	endfunction

	// Memory responses, driven just after the rising edge
	always @(posedge clk)
	begin
		#1;
		if (o_imem_addr !== imem_addr_seen)
		begin
			imem_addr_seen = o_imem_addr;
			imem_wait = draw_delay();
		end
		i_imem_rdata = imem[o_imem_addr[8:1]];
		i_imem_resp = (imem_wait == 0);
		if (imem_wait > 0)
			imem_wait--;
		if (dmem_retired)
		begin
			dmem_busy = 1'b0;
			dmem_retired = 1'b0;
		end
		if ((o_dmem_read || o_dmem_write) && !dmem_busy)
		begin
			dmem_busy = 1'b1;
			dmem_wait = draw_delay();
		end
		i_dmem_resp = dmem_busy && dmem_wait == 0;
		i_dmem_rdata = dmem[o_dmem_addr[8:1]];
		if (dmem_busy && dmem_wait > 0)
			dmem_wait--;
	end

	// An access ends when no memory holds the pipeline
	always @(negedge clk)
	begin
		if ((o_dmem_read || o_dmem_write) && i_dmem_resp && i_imem_resp)
			dmem_retired = 1'b1;
		if (running && o_dmem_write && i_dmem_resp && i_imem_resp)
		begin
			dmem[o_dmem_addr[8:1]] = o_dmem_wdata;
			if (store_idx < exp_addr.size())
			begin
				check_value("o_dmem_addr", o_dmem_addr, exp_addr[store_idx]);
				check_value("o_dmem_wdata", o_dmem_wdata, exp_data[store_idx]);
			end
			else
			begin
				errors++;
				$display("error at %0t: unexpected store of %h to %h after the last expected one",
					$time, o_dmem_wdata, o_dmem_addr);
			end
			store_idx++;
		end
		if (running)
		begin
			check_value("o_imem_read", 16'(o_imem_read), 16'h0001);
			// Final branch redirects from three words past itself
			if (o_imem_addr == halt_addr && prev_fetch == halt_addr + 16'd6)
				done = 1'b1;
			prev_fetch = o_imem_addr;
		end
	end

	task automatic run_test(input int id, input string label, input int prog, input logic rnd);
		int errors_before;
		errors_before = errors;
		@(posedge clk);
		#1;
		i_rst_n = 1'b0;
		running = 1'b0;
		rand_delays = rnd;
		load_program(prog);
		for (int i = 0; i < 256; i++)
		begin
			dmem[i] = fill_word(i);
		end
		run_reference();
		store_idx = 0;
		done = 1'b0;
		prev_fetch = 16'h0000;
		dmem_busy = 1'b0;
		dmem_retired = 1'b0;
		cycle_limit = prog_len * 30;
		repeat (8)
		begin
			@(negedge clk);
			check_value("o_dmem_read", 16'(o_dmem_read), 16'h0000);
			check_value("o_dmem_write", 16'(o_dmem_write), 16'h0000);
		end
		@(posedge clk);
		#1;
		i_rst_n = 1'b1;
		run_cycles = 0;
		running = 1'b1;
		@(negedge clk);
		check_value("o_imem_addr", o_imem_addr, `LC3B_PC_RESET);
		wait (done);
		running = 1'b0;
		check_value("store count", 16'(store_idx), 16'(exp_addr.size()));
		runs++;
		$display("test %0d %s, program %0d: %0d stores, %0d errors", id, label, prog,
			store_idx, errors - errors_before);
	endtask

	initial
	begin
		clk = 1'b0;
		i_rst_n = 1'b0;
		i_imem_resp = 1'b0;
		i_imem_rdata = 16'h0000;
		i_dmem_resp = 1'b0;
		i_dmem_rdata = 16'h0000;
		seed = 87;
		errors = 0;
		checks = 0;
		runs = 0;
		imem_wait = 0;
		dmem_wait = 0;
		imem_addr_seen = 16'hffff;
		rand_delays = 1'b0;
		run_test(1, "register chain", 1, 1'b0);
		run_test(2, "immediate chain", 2, 1'b0);
		run_test(3, "load use", 3, 1'b0);
		run_test(4, "branches", 4, 1'b0);
		for (int p = 1; p <= 4; p++)
		begin
			run_test(5, "random memory delays", p, 1'b1);
		end
		run_test(6, "reset during a running program", 4, 1'b1);
		$display("%0d runs, %0d checks, %0d errors", runs, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Watchdog limit scales with the program length
	initial
	begin
		while (!timed_out)
		begin
			@(posedge clk);
			if (running)
			begin
				run_cycles = run_cycles + 1;
				timed_out = run_cycles > cycle_limit;
			end
		end
		$display("timeout: program did not reach its final branch within %0d cycles", cycle_limit);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* flist.f */
+incdir+hdl
hdl/lc3b_isa_pkg.sv
hdl/lc3b_pipe_pkg.sv
hdl/lc3b_fetch.sv
hdl/lc3b_decode.sv
hdl/lc3b_execute.sv
hdl/lc3b_memory.sv
hdl/lc3b_cpu_datapath.sv
verif/lc3b_tb.sv

/* Bender.yml */
package:
  name: lc3b_pipeline

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lc3b_isa_pkg.sv
      - hdl/lc3b_pipe_pkg.sv
      - hdl/lc3b_fetch.sv
      - hdl/lc3b_decode.sv
      - hdl/lc3b_execute.sv
      - hdl/lc3b_memory.sv
      - hdl/lc3b_cpu_datapath.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/lc3b_tb.sv
